// File: list.f
+incdir+verification
verilog/keccakPkg.sv
verilog/widthFunnel.sv
verilog/chunkCounter.sv
verilog/keccakRound.sv
verilog/keccakCore.sv
verilog/keccakHasher.sv
verification/clockGen.sv
verification/keccakHasherTb.sv

// File: run.sh
#!/bin/sh
set -e
for bytes in 16 20; do
	verilator --binary --timing --assert -f list.f --top-module keccakHasherTb \
		-GHashByteCount=$bytes --Mdir obj_dir_$bytes -o simv
	out=$(./obj_dir_$bytes/simv)
	echo "$out"
	echo "$out" | grep -q "Simulation PASSED"
done

// File: verification/clockGen.sv
module clockGen #(
	parameter int Period = 8
) (
	output logic clock
);

	initial begin
		clock = 1'b0;
		forever begin
			#(Period / 2) clock = ~clock;
		end
	end

endmodule

// File: verification/keccakModel.svh
`ifndef KECCAK_MODEL_SVH
`define KECCAK_MODEL_SVH

// Lane rotation, n from 0 to 63
function automatic laneT rotateLeft(input laneT v, input int n);
	return (v << n) | (v >> ((64 - n) % 64));
endfunction

// Keccak-512 of the first HashByteCount bytes of a word, 0x01 then 0x80 padding
function automatic digestT modelDigest(input wordT word);
	laneT st [25];
	laneT row [5];
	laneT moving;
	laneT held;
	laneT rc;
	logic [7:0] lfsr;
	digestT digest;
	int x;
	int y;
	int nx;
	for (int i = 0; i < 25; i++) begin
		st[i] = '0;
	end
	for (int i = 0; i < HashByteCount; i++) begin
		st[i / 8][8 * (i % 8) +: 8] = word[8 * i +: 8];
	end
	st[HashByteCount / 8][8 * (HashByteCount % 8) +: 8] ^= 8'h01;
	st[8][63:56] ^= 8'h80;
	lfsr = 8'h01;
	for (int r = 0; r < 24; r++) begin
		// Theta
		for (int i = 0; i < 5; i++) begin
			row[i] = st[i] ^ st[i + 5] ^ st[i + 10] ^ st[i + 15] ^ st[i + 20];
		end
		for (int i = 0; i < 25; i++) begin
			st[i] ^= row[(i + 4) % 5] ^ rotateLeft(row[(i + 1) % 5], 1);
		end
		// Rho and pi walk the 24 moving lanes starting at (1, 0)
		x = 1;
		y = 0;
		moving = st[1];
		for (int t = 0; t < 24; t++) begin
			nx = y;
			y = (2 * x + 3 * y) % 5;
			x = nx;
			held = st[x + 5 * y];
			st[x + 5 * y] = rotateLeft(moving, ((t + 1) * (t + 2) / 2) % 64);
			moving = held;
		end
		// Chi row by row
		for (int j = 0; j < 25; j += 5) begin
			for (int i = 0; i < 5; i++) begin
				row[i] = st[j + i];
			end
			for (int i = 0; i < 5; i++) begin
				st[j + i] = row[i] ^ (~row[(i + 1) % 5] & row[(i + 2) % 5]);
			end
		end
		// Iota bits sit at 2^k - 1 and come from the LFSR x^8 + x^6 + x^5 + x^4 + 1
		rc = '0;
		for (int k = 0; k < 7; k++) begin
			rc[(1 << k) - 1] = lfsr[0];
			lfsr = lfsr[7] ? ((lfsr << 1) ^ 8'h71) : (lfsr << 1);
		end
		st[0] ^= rc;
	end
	for (int i = 0; i < 8; i++) begin
		digest[64 * i +: 64] = st[i];
	end
	return digest;
endfunction

`endif

// File: verification/keccakHasherTb.sv
module keccakHasherTb import keccakPkg::*; #(
	parameter int HashByteCount = 20
);

	localparam int IWidth = 512;
	// Thirteen hashes of up to 200 cycles each plus margin for reset and gaps
	localparam int TestHashes = 13;
	localparam int CyclesPerHash = 200;
	localparam int TimeoutCycles = TestHashes * CyclesPerHash + 400;

	typedef logic [IWidth-1:0] wordT;

	logic   clock;
	logic   rstN;
	wordT   dataIn;
	logic   dataInValid;
	logic   dataInReady;
	digestT hashOut;
	logic   hashOutValid;
	logic   hashOutReady;
	int     seed = 68;
	int     cycleCount = 0;

	`include "keccakModel.svh"

	clockGen #(.Period(8)) clockSource (.clock(clock));

	keccakHasher #(.IWidth(IWidth), .HashByteCount(HashByteCount)) uut (
		.clock       (clock),
		.rstN        (rstN),
		.dataIn      (dataIn),
		.dataInValid (dataInValid),
		.dataInReady (dataInReady),
		.hashOut     (hashOut),
		.hashOutValid(hashOutValid),
		.hashOutReady(hashOutReady)
	);

	// ==============================
	// Reporting and timeout
	task automatic abortRun(input string reason);
		$display("%s", reason);
		$display("Simulation FAILED");
		$fatal(1, "Stopped at the first failure");
	endtask

	always @(posedge clock) begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= TimeoutCycles) begin
			abortRun($sformatf("Timeout after %0d cycles, the DUT stopped responding", cycleCount));
		end
	end

	task automatic checkDigest(input string testName, input digestT expected,
		input digestT actual);
		if (actual !== expected) begin
			abortRun($sformatf("[ERROR] %s: expected %h, actual %h", testName, expected, actual));
		end
	endtask

	task automatic checkFlag(input string testName, input logic expected, input logic actual);
		if (actual !== expected) begin
			abortRun($sformatf("[ERROR] %s: expected %b, actual %b", testName, expected, actual));
		end
	endtask

	// ==============================
	// Inputs change 1 unit after the edge and outputs are read at the falling edge
	task automatic nextDriveSlot();
		@(posedge clock);
		#1;
	endtask

	function automatic wordT randomWord();
		wordT w;
		for (int k = 0; k < IWidth / 32; k++) begin
			w[32 * k +: 32] = $random(seed);
		end
		return w;
	endfunction

	task automatic sendWord(input wordT word);
		logic accepted;
		accepted = 1'b0;
		dataIn = word;
		dataInValid = 1'b1;
		while (!accepted) begin
			@(negedge clock);
			accepted = dataInReady;
			nextDriveSlot();
		end
		dataInValid = 1'b0;
	endtask

	task automatic waitForValid();
		logic seen;
		seen = 1'b0;
		while (!seen) begin
			@(negedge clock);
			seen = hashOutValid;
			nextDriveSlot();
		end
	endtask

	task automatic takeDigest(output digestT digest);
		logic taken;
		taken = 1'b0;
		hashOutReady = 1'b1;
		while (!taken) begin
			@(negedge clock);
			taken = hashOutValid;
			digest = hashOut;
			nextDriveSlot();
		end
		hashOutReady = 1'b0;
	endtask

	// ==============================
	// Directed tests
	task automatic resetState();
		@(negedge clock);
		checkFlag("resetState", 1'b0, hashOutValid);
		nextDriveSlot();
	endtask

	task automatic singleHash();
		wordT word;
		digestT got;
		for (int k = 0; k < IWidth / 8; k++) begin
			word[8 * k +: 8] = 8'(7 * k + 3);
		end
		sendWord(word);
		takeDigest(got);
		checkDigest("singleHash", modelDigest(word), got);
	endtask

	// Bytes above the message are flipped and must not matter
	task automatic ignoredTail();
		wordT base;
		wordT other;
		digestT gotBase;
		digestT gotOther;
		base = randomWord();
		other = base ^ ({IWidth{1'b1}} << (8 * HashByteCount));
		sendWord(base);
		takeDigest(gotBase);
		sendWord(other);
		takeDigest(gotOther);
		checkDigest("ignoredTail", modelDigest(base), gotBase);
		checkDigest("ignoredTail", modelDigest(base), gotOther);
	endtask

	task automatic backToBack();
		wordT words [8];
		int gaps [8];
		digestT got;
		for (int i = 0; i < 8; i++) begin
			words[i] = randomWord();
			gaps[i] = $unsigned($random(seed)) % 6;
		end
		fork
			begin
				for (int i = 0; i < 8; i++) begin
					repeat (gaps[i]) nextDriveSlot();
					sendWord(words[i]);
				end
			end
			begin
				for (int i = 0; i < 8; i++) begin
					takeDigest(got);
					checkDigest("backToBack", modelDigest(words[i]), got);
				end
			end
		join
	endtask

	// Second word waits in the funnel while the first digest is held
	task automatic backPressure();
		wordT first;
		wordT second;
		digestT expFirst;
		digestT got;
		first = randomWord();
		second = randomWord();
		expFirst = modelDigest(first);
		hashOutReady = 1'b0;
		sendWord(first);
		sendWord(second);
		waitForValid();
		repeat (40) begin
			@(negedge clock);
			checkFlag("backPressure", 1'b1, hashOutValid);
			checkFlag("backPressure", 1'b0, dataInReady);
			checkDigest("backPressure", expFirst, hashOut);
			nextDriveSlot();
		end
		takeDigest(got);
		checkDigest("backPressure", expFirst, got);
		takeDigest(got);
		checkDigest("backPressure", modelDigest(second), got);
	endtask

	initial begin
		rstN = 1'b0;
		dataIn = '0;
		dataInValid = 1'b0;
		hashOutReady = 1'b0;
		repeat (4) @(posedge clock);
		#1;
		rstN = 1'b1;
		resetState();
		singleHash();
		ignoredTail();
		backToBack();
		backPressure();
		$display("Simulation PASSED");
		$finish;
	end

endmodule

// File: verilog/chunkCounter.sv
module chunkCounter #(
	parameter int Threshold = 3
) (
	input  logic clock,
	input  logic rstN,
	input  logic advance,
	output logic nextIsLast,
	output logic isLast
);

	localparam int CountWidth = $clog2(Threshold + 1);

	logic [CountWidth-1:0] count;

	always_ff @(posedge clock) begin
		if (!rstN) begin
			count <= '0;
		end else if (advance) begin
			// Wrap after the final chunk, ready for the next message
			count <= isLast ? '0 : count + 1'b1;
		end
	end

	assign isLast = count == CountWidth'(Threshold - 1);

	// Only meaningful when a message has two chunks or more
	assign nextIsLast = (Threshold > 1) && (count == CountWidth'(Threshold - 2));

	// Accepting the next-to-last chunk hands over to the last one alone
	lastFollows: assert property (@(posedge clock) disable iff (!rstN)
		(advance && nextIsLast) |=> (isLast && !nextIsLast));

endmodule

// File: verilog/keccakCore.sv
module keccakCore import keccakPkg::*; #(
	parameter int LastLaneBytes = 4
) (
	input  logic      clock,
	input  logic      rstN,
	input  hashChunkT chunk,
	input  logic      chunkValid,
	output logic      chunkReady,
	output digestT    hashOut,
	output logic      hashValid,
	input  logic      hashReady
);

	localparam int LaneIdxWidth = $clog2(RateLanes);
	localparam int RoundIdxWidth = $clog2(RoundCount);

	// Message bytes kept from the final lane, and the 0x01 pad just above them
	localparam laneT LastMask = ~({64{1'b1}} << (8 * LastLaneBytes));
	localparam laneT PadStart = 64'h1 << (8 * LastLaneBytes);

	typedef enum logic [1:0] {
		absorbing,
		permuting,
		done
	} phaseT;

	phaseT                    phase;
	logic [LaneIdxWidth-1:0]  laneIdx;
	logic [RoundIdxWidth-1:0] roundIdx;
	logic [1599:0]            state;
	logic [1599:0]            padVec;
	logic [1599:0]            roundIn;
	logic [1599:0]            roundOut;
	laneT                     absorbLane;
	logic                     chunkFire;

	assign chunkReady = phase == absorbing;
	assign chunkFire = chunkValid && chunkReady;
	assign absorbLane = chunk.last ? (chunk.lane & LastMask) : chunk.lane;

	// laneIdx still points at the final lane once absorbing ends
	always_comb begin
		padVec = '0;
		padVec[64*laneIdx +: 64] = PadStart;
		padVec[64*8 + 56 +: 8] = padVec[64*8 + 56 +: 8] ^ 8'h80;
	end

	// Padding folds into the first round
	assign roundIn = (roundIdx == '0) ? (state ^ padVec) : state;

	keccakRound round (
		.stateIn   (roundIn),
		.roundConst(roundConstant(5'(roundIdx))),
		.stateOut  (roundOut)
	);

	// ==============================
	// Phase sequencing
	always_ff @(posedge clock) begin
		if (!rstN) begin
			phase <= absorbing;
			laneIdx <= '0;
			roundIdx <= '0;
		end else begin
			case (phase)
				absorbing: if (chunkFire) begin
					if (chunk.last) begin
						phase <= permuting;
					end else begin
						laneIdx <= laneIdx + 1'b1;
					end
				end
				permuting: begin
					roundIdx <= roundIdx + 1'b1;
					if (roundIdx == RoundIdxWidth'(RoundCount - 1)) begin
						roundIdx <= '0;
						phase <= done;
					end
				end
				default: if (hashReady) begin
					phase <= absorbing;
					laneIdx <= '0;
				end
			endcase
		end
	end

	// ==============================
	// The first lane of a message overwrites the old state with zeros
	always_ff @(posedge clock) begin
		if (chunkFire) begin
			if (laneIdx == '0) begin
				state <= 1600'(absorbLane);
			end else begin
				state[64*laneIdx +: 64] <= state[64*laneIdx +: 64] ^ absorbLane;
			end
		end else if (phase == permuting) begin
			state <= roundOut;
		end
	end

	assign hashOut = state[511:0];
	assign hashValid = phase == done;

	// Lanes only go into the rate
	laneInRate: assert property (@(posedge clock) disable iff (!rstN)
		chunkFire |-> (laneIdx < LaneIdxWidth'(RateLanes)));

endmodule

// File: verilog/keccakHasher.sv
module keccakHasher import keccakPkg::*; #(
	parameter int IWidth = 512,
	parameter int HashByteCount = 20
) (
	input  logic              clock,
	input  logic              rstN,
	input  logic [IWidth-1:0] dataIn,
	input  logic              dataInValid,
	output logic              dataInReady,
	output digestT            hashOut,
	output logic              hashOutValid,
	input  logic              hashOutReady
);

	localparam int LaneBytes = 8;
	localparam int ChunkCount = HashByteCount / LaneBytes + 1;
	localparam int LastLaneBytes = HashByteCount % LaneBytes;

	// Message ends on a lane boundary, so the final chunk carries only padding
	localparam bit ExactLanes = LastLaneBytes == 0;

	laneT      funnelLane;
	logic      funnelValid;
	logic      funnelReady;
	hashChunkT chunk;
	logic      chunkValid;
	logic      chunkReady;
	logic      chunkFire;
	logic      nextIsLast;
	logic      isLast;
	logic      padChunk;
	logic      flush;

	assign padChunk = ExactLanes && isLast;
	assign chunkValid = padChunk || funnelValid;
	assign chunk = '{lane: padChunk ? '0 : funnelLane, last: isLast};
	assign funnelReady = chunkReady && !padChunk;
	assign chunkFire = chunkValid && chunkReady;

	// Drop the unused tail of the word once the message bytes are all taken
	assign flush = chunkFire && (ExactLanes ? nextIsLast : isLast);

	widthFunnel #(.IWidth(IWidth)) funnel (
		.clock   (clock),
		.rstN    (rstN),
		.flush   (flush),
		.inData  (dataIn),
		.inValid (dataInValid),
		.inReady (dataInReady),
		.outLane (funnelLane),
		.outValid(funnelValid),
		.outReady(funnelReady)
	);

	chunkCounter #(.Threshold(ChunkCount)) counter (
		.clock     (clock),
		.rstN      (rstN),
		.advance   (chunkFire),
		.nextIsLast(nextIsLast),
		.isLast    (isLast)
	);

	keccakCore #(.LastLaneBytes(LastLaneBytes)) core (
		.clock     (clock),
		.rstN      (rstN),
		.chunk     (chunk),
		.chunkValid(chunkValid),
		.chunkReady(chunkReady),
		.hashOut   (hashOut),
		.hashValid (hashOutValid),
		.hashReady (hashOutReady)
	);

endmodule

// File: verilog/keccakPkg.sv
package keccakPkg;

	typedef logic [63:0] laneT;

	// One lane offered to the core, last marks the final chunk of a message
	typedef struct packed {
		laneT lane;
		logic last;
	} hashChunkT;

	// Lanes 0 to 7 of the final state, lane 0 in the low bits
	typedef logic [511:0] digestT;

	// Keccak-512 rate is 576 bits
	localparam int RateLanes = 9;
	localparam int RoundCount = 24;

	// Iota constants of Keccak-f[1600]
	function automatic laneT roundConstant(input logic [4:0] round);
		case (round)
			5'd0:    roundConstant = 64'h0000_0000_0000_0001;
			5'd1:    roundConstant = 64'h0000_0000_0000_8082;
			5'd2:    roundConstant = 64'h8000_0000_0000_808A;
			5'd3:    roundConstant = 64'h8000_0000_8000_8000;
			5'd4:    roundConstant = 64'h0000_0000_0000_808B;
			5'd5:    roundConstant = 64'h0000_0000_8000_0001;
			5'd6:    roundConstant = 64'h8000_0000_8000_8081;
			5'd7:    roundConstant = 64'h8000_0000_0000_8009;
			5'd8:    roundConstant = 64'h0000_0000_0000_008A;
			5'd9:    roundConstant = 64'h0000_0000_0000_0088;
			5'd10:   roundConstant = 64'h0000_0000_8000_8009;
			5'd11:   roundConstant = 64'h0000_0000_8000_000A;
			5'd12:   roundConstant = 64'h0000_0000_8000_808B;
			5'd13:   roundConstant = 64'h8000_0000_0000_008B;
			5'd14:   roundConstant = 64'h8000_0000_0000_8089;
			5'd15:   roundConstant = 64'h8000_0000_0000_8003;
			5'd16:   roundConstant = 64'h8000_0000_0000_8002;
			5'd17:   roundConstant = 64'h8000_0000_0000_0080;
			5'd18:   roundConstant = 64'h0000_0000_0000_800A;
			5'd19:   roundConstant = 64'h8000_0000_8000_000A;
			5'd20:   roundConstant = 64'h8000_0000_8000_8081;
			5'd21:   roundConstant = 64'h8000_0000_0000_8080;
			5'd22:   roundConstant = 64'h0000_0000_8000_0001;
			5'd23:   roundConstant = 64'h8000_0000_8000_8008;
			default: roundConstant = '0;
		endcase
	endfunction

endpackage

// File: verilog/keccakRound.sv
module keccakRound import keccakPkg::*; (
	input  logic [1599:0] stateIn,
	input  laneT          roundConst,
	output logic [1599:0] stateOut
);

	// Rho offsets, indexed by lane x + 5y
	localparam int RhoOffset [25] = '{
		0, 1, 62, 28, 27,
		36, 44, 6, 55, 20,
		3, 10, 43, 25, 39,
		41, 45, 15, 21, 8,
		18, 2, 61, 56, 14
	};

	laneT a [25];
	laneT b [25];
	laneT e [25];
	laneT c [5];
	laneT d [5];

	function automatic laneT rotl(input laneT v, input int n);
		rotl = (n == 0) ? v : ((v << n) | (v >> (64 - n)));
	endfunction

	always_comb begin
		for (int i = 0; i < 25; i++) begin
			a[i] = stateIn[64*i +: 64];
		end

		// ==============================
		// Theta
		for (int x = 0; x < 5; x++) begin
			c[x] = a[x] ^ a[x+5] ^ a[x+10] ^ a[x+15] ^ a[x+20];
		end
		for (int x = 0; x < 5; x++) begin
			d[x] = c[(x+4)%5] ^ rotl(c[(x+1)%5], 1);
		end

		// ==============================
		// Rho and pi, lane (x, y) moves to (y, 2x + 3y)
		for (int x = 0; x < 5; x++) begin
			for (int y = 0; y < 5; y++) begin
				b[y + 5*((2*x + 3*y) % 5)] = rotl(a[x + 5*y] ^ d[x], RhoOffset[x + 5*y]);
			end
		end

		// ==============================
		// Chi, then iota on lane 0
		for (int x = 0; x < 5; x++) begin
			for (int y = 0; y < 5; y++) begin
				e[x + 5*y] = b[x + 5*y] ^ (~b[(x+1)%5 + 5*y] & b[(x+2)%5 + 5*y]);
			end
		end
		e[0] = e[0] ^ roundConst;

		for (int i = 0; i < 25; i++) begin
			stateOut[64*i +: 64] = e[i];
		end
	end

endmodule

// File: verilog/widthFunnel.sv
module widthFunnel import keccakPkg::*; #(
	parameter int IWidth = 512
) (
	input  logic              clock,
	input  logic              rstN,
	input  logic              flush,
	input  logic [IWidth-1:0] inData,
	input  logic              inValid,
	output logic              inReady,
	output laneT              outLane,
	output logic              outValid,
	input  logic              outReady
);

	localparam int LaneCount = (IWidth + 63) / 64;
	localparam int BufWidth = LaneCount * 64;
	localparam int IdxWidth = $clog2(LaneCount + 1);

	logic [BufWidth-1:0] buffer;
	logic [IdxWidth-1:0] laneIdx;
	logic                full;
	logic                finalLane;
	logic                emptying;

	// Lowest lane always sits at the bottom of the shift buffer
	assign outValid = full;
	assign outLane = buffer[63:0];

	assign finalLane = laneIdx == IdxWidth'(LaneCount - 1);
	assign emptying = flush || (outValid && outReady && finalLane);

	// A new word may replace the one that is leaving in the same cycle
	assign inReady = !full || emptying;

	always_ff @(posedge clock) begin
		if (!rstN) begin
			full <= 1'b0;
			laneIdx <= '0;
		end else if (inValid && inReady) begin
			full <= 1'b1;
			laneIdx <= '0;
		end else if (emptying) begin
			full <= 1'b0;
		end else if (outValid && outReady) begin
			laneIdx <= laneIdx + 1'b1;
		end
	end

	always_ff @(posedge clock) begin
		if (inValid && inReady) begin
			buffer <= BufWidth'(inData);
		end else if (outValid && outReady) begin
			buffer <= buffer >> 64;
		end
	end

	// Offered lane must not change while the consumer stalls
	laneStable: assert property (@(posedge clock) disable iff (!rstN)
		(outValid && !outReady) |=> (outValid && $stable(outLane)));

endmodule
